/* src/cachePkg.sv */
package cachePkg;

    localparam int AddrWidth = 32;
    localparam int WordWidth = 32;
    localparam int LineWords = 4;
    localparam int IndexBits = 4;
    localparam int MaskBits = WordWidth / 8;
    localparam int ByteOffBits = $clog2(MaskBits);
    localparam int WordSelBits = $clog2(LineWords);
    localparam int LineOffBits = ByteOffBits + WordSelBits;
    localparam int TagBits = AddrWidth - IndexBits - LineOffBits;
    localparam int NumLines = 2 ** IndexBits;

    // top nibble of a cacheable address
    localparam logic [3:0] CachedRegion = 4'h8;

    // fixed controller state encodings
    typedef enum logic [2:0] {
        idle      = 3'b000,
        compare   = 3'b001,
        miss      = 3'b010,
        getData   = 3'b011,
        replace   = 3'b111,
        uncacheOp = 3'b110
    } cacheState_e;

    typedef enum logic {
        opRead  = 1'b0,
        opWrite = 1'b1
    } cpuOp_e;

    typedef struct packed {
        logic                 valid;
        cpuOp_e               op;
        logic [AddrWidth-1:0] addr;
        logic [WordWidth-1:0] wrData;
        logic [MaskBits-1:0]  wrMask;
    } cpuReq_t;

    typedef struct packed {
        logic                 valid;
        logic [WordWidth-1:0] rdData;
    } cpuRsp_t;

    // byte-enable merge used by the cache and the memory
    function automatic logic [WordWidth-1:0] mergeBytes(
        input logic [WordWidth-1:0] oldWord,
        input logic [WordWidth-1:0] newWord,
        input logic [MaskBits-1:0]  byteEn
    );
        logic [WordWidth-1:0] merged;
        merged = oldWord;
        for (int b = 0; b < MaskBits; b++) begin
            if (byteEn[b]) begin
                merged[b*8 +: 8] = newWord[b*8 +: 8];
            end
        end
        return merged;
    endfunction

endpackage

/* src/busPkg.sv */
package busPkg;

    import cachePkg::*;

    localparam int LineWidth = LineWords * WordWidth;

    // memory request queue depth and response delay
    localparam int MemCredits = 2;
    localparam int MemLatency = 3;
    localparam int CreditBits = $clog2(MemCredits + 1);

    // word addresses wrap at this size
    localparam int MemWords = 1024;
    localparam int MemAddrBits = $clog2(MemWords);

    typedef enum logic [1:0] {
        busRdLine = 2'b00,
        busWrLine = 2'b01,
        busRdWord = 2'b10,
        busWrWord = 2'b11
    } busOp_e;

    typedef struct packed {
        logic                 valid;
        busOp_e               op;
        logic [AddrWidth-1:0] addr;
        logic [LineWidth-1:0] data;
        logic [MaskBits-1:0]  mask;
        logic                 src;
    } busReq_t;

    // word reads return their word in the low bits of data
    typedef struct packed {
        logic                 valid;
        logic                 src;
        logic [LineWidth-1:0] data;
    } busRsp_t;

endpackage

/* src/dataCache.sv */
`timescale 1ns/10ps

module dataCache import cachePkg::*; import busPkg::*; #(
    parameter bit SrcId = 1'b0
) (
    input  logic    clk,
    input  logic    rst_n,
    input  cpuReq_t cpuReq_i,
    output logic    reqReady_o,
    output cpuRsp_t cpuRsp_o,
    output busReq_t busReq_o,
    input  logic    busGrant_i,
    input  busRsp_t busRsp_i
);

    cacheState_e state;
    cacheState_e nextState;

    // line storage
    logic [LineWords-1:0][WordWidth-1:0] dataArr [NumLines];
    logic [TagBits-1:0]                  tagArr  [NumLines];
    logic [NumLines-1:0]                 validArr;
    logic [NumLines-1:0]                 dirtyArr;

    cpuReq_t                             reqLatch;
    logic [LineWords-1:0][WordWidth-1:0] lineBuf;
    logic                                wbPending;
    logic                                uncSent;

    logic [IndexBits-1:0]   reqIdx;
    logic [TagBits-1:0]     reqTag;
    logic [WordSelBits-1:0] reqWord;
    logic                   uncached;
    logic                   lineHit;
    logic                   hitDone;
    logic                   hitWrite;
    logic                   uncDone;
    logic                   reqAccept;
    logic [WordWidth-1:0]   hitWord;

    assign reqIdx   = reqLatch.addr[LineOffBits +: IndexBits];
    assign reqTag   = reqLatch.addr[AddrWidth-1 -: TagBits];
    assign reqWord  = reqLatch.addr[ByteOffBits +: WordSelBits];
    assign uncached = reqLatch.addr[AddrWidth-1 -: 4] != CachedRegion;
    assign lineHit  = !uncached && validArr[reqIdx] && (tagArr[reqIdx] == reqTag);
    assign hitWord  = dataArr[reqIdx][reqWord];

    assign hitDone   = (state == compare) && lineHit;
    assign hitWrite  = hitDone && (reqLatch.op == opWrite);
    assign uncDone   = (state == uncacheOp) && uncSent && busRsp_i.valid;
    // a new request may follow a hit back to back
    assign reqReady_o = (state == idle) || hitDone;
    assign reqAccept  = cpuReq_i.valid && reqReady_o;

    assign cpuRsp_o.valid  = hitDone || uncDone;
    assign cpuRsp_o.rdData = uncDone ? busRsp_i.data[WordWidth-1:0] : hitWord;

    always_comb begin
        nextState = state;
        case (state)
            idle: begin
                if (reqAccept) begin
                    nextState = compare;
                end
            end
            compare: begin
                if (uncached) begin
                    nextState = uncacheOp;
                end else if (lineHit) begin
                    nextState = reqAccept ? compare : idle;
                end else begin
                    nextState = miss;
                end
            end
            miss: begin
                if (busGrant_i) begin
                    nextState = getData;
                end
            end
            getData: begin
                // a writeback ack sends us back for the refill
                if (busRsp_i.valid) begin
                    nextState = wbPending ? miss : replace;
                end
            end
            replace: begin
                nextState = compare;
            end
            uncacheOp: begin
                if (uncDone) begin
                    nextState = idle;
                end
            end
            default: begin
                nextState = idle;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= idle;
            wbPending <= 1'b0;
            uncSent   <= 1'b0;
        end else begin
            state <= nextState;
            if (state == compare && !uncached && !lineHit) begin
                wbPending <= validArr[reqIdx] && dirtyArr[reqIdx];
            end else if (state == getData && busRsp_i.valid) begin
                wbPending <= 1'b0;
            end
            if (state == compare) begin
                uncSent <= 1'b0;
            end else if (state == uncacheOp && busGrant_i) begin
                uncSent <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            validArr <= '0;
            dirtyArr <= '0;
        end else if (state == replace) begin
            validArr[reqIdx] <= 1'b1;
            dirtyArr[reqIdx] <= 1'b0;
        end else if (hitWrite) begin
            dirtyArr[reqIdx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reqAccept) begin
            reqLatch <= cpuReq_i;
        end
        if (state == getData && busRsp_i.valid && !wbPending) begin
            lineBuf <= busRsp_i.data;
        end
        if (state == replace) begin
            tagArr[reqIdx]  <= reqTag;
            dataArr[reqIdx] <= lineBuf;
        end else if (hitWrite) begin
            dataArr[reqIdx][reqWord] <= mergeBytes(hitWord, reqLatch.wrData, reqLatch.wrMask);
        end
    end

    always_comb begin
        busReq_o      = '0;
        busReq_o.src  = SrcId;
        busReq_o.mask = reqLatch.wrMask;
        if (state == miss) begin
            busReq_o.valid = 1'b1;
            if (wbPending) begin
                // victim line goes out first
                busReq_o.op   = busWrLine;
                busReq_o.addr = {tagArr[reqIdx], reqIdx, {LineOffBits{1'b0}}};
                busReq_o.data = dataArr[reqIdx];
            end else begin
                busReq_o.op   = busRdLine;
                busReq_o.addr = {reqTag, reqIdx, {LineOffBits{1'b0}}};
            end
        end else if (state == uncacheOp) begin
            busReq_o.valid = !uncSent;
            busReq_o.op    = (reqLatch.op == opWrite) ? busWrWord : busRdWord;
            busReq_o.addr  = reqLatch.addr;
            busReq_o.data  = LineWidth'(reqLatch.wrData);
        end
    end

    // a bus response only arrives for the one request outstanding
    assert property (@(posedge clk) disable iff (!rst_n)
        busRsp_i.valid |-> (state == getData) || (state == uncacheOp && uncSent));

    // back-to-back responses only come from pipelined hits
    assert property (@(posedge clk) disable iff (!rst_n)
        cpuRsp_o.valid && $past(cpuRsp_o.valid) |-> $past(hitDone && reqAccept) && hitDone);

endmodule

/* src/busArbiter.sv */
`timescale 1ns/10ps

module busArbiter import busPkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    input  busReq_t cacheReq_i [2],
    output logic [1:0] busGrant_o,
    output busReq_t memReq_o,
    input  logic    creditReturn_i,
    input  busRsp_t memRsp_i,
    output busRsp_t cacheRsp_o [2]
);

    logic [CreditBits-1:0] creditCnt;
    logic                  rrPtr;
    logic                  winner;
    logic                  grantAny;
    logic [1:0]            reqVec;

    assign reqVec   = {cacheReq_i[1].valid, cacheReq_i[0].valid};
    // rrPtr only matters when both lanes ask
    assign winner   = (reqVec == 2'b11) ? rrPtr : reqVec[1];
    assign grantAny = (|reqVec) && (creditCnt != '0);

    assign busGrant_o = grantAny ? (winner ? 2'b10 : 2'b01) : 2'b00;

    always_comb begin
        memReq_o       = cacheReq_i[winner];
        memReq_o.valid = grantAny;
        memReq_o.src   = winner;
    end

    // steer each response back by source id
    always_comb begin
        for (int i = 0; i < 2; i++) begin
            cacheRsp_o[i]       = memRsp_i;
            cacheRsp_o[i].valid = memRsp_i.valid && (memRsp_i.src == 1'(i));
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            creditCnt <= CreditBits'(MemCredits);
            rrPtr     <= 1'b0;
        end else begin
            case ({grantAny, creditReturn_i})
                2'b10: creditCnt <= creditCnt - 1'b1;
                2'b01: creditCnt <= creditCnt + 1'b1;
                default: creditCnt <= creditCnt;
            endcase
            // priority moves past the lane just served
            if (grantAny) begin
                rrPtr <= ~winner;
            end
        end
    end

    // a credit only comes back while one is out
    assert property (@(posedge clk) disable iff (!rst_n)
        creditReturn_i |-> creditCnt != CreditBits'(MemCredits));

    assert property (@(posedge clk) disable iff (!rst_n)
        creditCnt <= CreditBits'(MemCredits));

endmodule

/* src/backingMemory.sv */
`timescale 1ns/10ps

module backingMemory import cachePkg::*; import busPkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    input  busReq_t memReq_i,
    output busRsp_t memRsp_o,
    output logic    creditReturn_o
);

    logic [WordWidth-1:0]   memArr [MemWords];
    busReq_t                pipe   [MemLatency];
    busReq_t                headReq;
    logic [MemAddrBits-1:0] wordAddr;
    logic [MemLatency-1:0]  stageValid;

    initial begin
        for (int w = 0; w < MemWords; w++) begin
            memArr[w] = '0;
        end
    end

    assign headReq        = pipe[MemLatency-1];
    assign wordAddr       = headReq.addr[ByteOffBits +: MemAddrBits];
    assign creditReturn_o = headReq.valid;

    // fixed delay line with the access done at the head
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int s = 0; s < MemLatency; s++) begin
                pipe[s] <= '0;
            end
        end else begin
            pipe[0] <= memReq_i;
            for (int s = 1; s < MemLatency; s++) begin
                pipe[s] <= pipe[s-1];
            end
        end
    end

    always_comb begin
        memRsp_o       = '0;
        memRsp_o.valid = headReq.valid;
        memRsp_o.src   = headReq.src;
        if (headReq.op == busRdLine) begin
            for (int w = 0; w < LineWords; w++) begin
                memRsp_o.data[w*WordWidth +: WordWidth] =
                    memArr[{wordAddr[MemAddrBits-1:WordSelBits], WordSelBits'(w)}];
            end
        end else if (headReq.op == busRdWord) begin
            memRsp_o.data[WordWidth-1:0] = memArr[wordAddr];
        end
    end

    always_ff @(posedge clk) begin
        if (headReq.valid && headReq.op == busWrLine) begin
            for (int w = 0; w < LineWords; w++) begin
                memArr[{wordAddr[MemAddrBits-1:WordSelBits], WordSelBits'(w)}] <=
                    headReq.data[w*WordWidth +: WordWidth];
            end
        end else if (headReq.valid && headReq.op == busWrWord) begin
            memArr[wordAddr] <= mergeBytes(memArr[wordAddr], headReq.data[WordWidth-1:0],
                                           headReq.mask);
        end
    end

    always_comb begin
        for (int s = 0; s < MemLatency; s++) begin
            stageValid[s] = pipe[s].valid;
        end
    end

    // arbiter credits bound the queue occupancy
    assert property (@(posedge clk) disable iff (!rst_n)
        $countones(stageValid) <= MemCredits);

endmodule

/* src/memSubsystem.sv */
`timescale 1ns/10ps

module memSubsystem import cachePkg::*; import busPkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  cpuReq_t    cpuReq_i [2],
    output logic [1:0] reqReady_o,
    output cpuRsp_t    cpuRsp_o [2]
);

    busReq_t    cacheReq [2];
    busRsp_t    cacheRsp [2];
    logic [1:0] busGrant;
    busReq_t    memReq;
    busRsp_t    memRsp;
    logic       creditReturn;

    // one cache per load/store lane
    for (genvar lane = 0; lane < 2; lane++) begin : genLane
        dataCache #(
            .SrcId(lane)
        ) dataCache_i (
            .clk       (clk),
            .rst_n     (rst_n),
            .cpuReq_i  (cpuReq_i[lane]),
            .reqReady_o(reqReady_o[lane]),
            .cpuRsp_o  (cpuRsp_o[lane]),
            .busReq_o  (cacheReq[lane]),
            .busGrant_i(busGrant[lane]),
            .busRsp_i  (cacheRsp[lane])
        );
    end

    busArbiter busArbiter_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .cacheReq_i    (cacheReq),
        .busGrant_o    (busGrant),
        .memReq_o      (memReq),
        .creditReturn_i(creditReturn),
        .memRsp_i      (memRsp),
        .cacheRsp_o    (cacheRsp)
    );

    backingMemory backingMemory_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .memReq_i      (memReq),
        .memRsp_o      (memRsp),
        .creditReturn_o(creditReturn)
    );

endmodule

/* dv/memSubsystemTb.sv */
`timescale 1ns/10ps

module memSubsystemTb import cachePkg::*; import busPkg::*; ();

    localparam int ClkPeriod = 40;
    localparam int RandReqs = 40;
    localparam int DirectedReqs = 14;
    localparam int TotalReqs = DirectedReqs + 2 * RandReqs;
    localparam int WatchdogCycles = 200 * TotalReqs + 20;

    typedef struct packed {
        logic                 isRead;
        logic [WordWidth-1:0] data;
    } expRsp_t;

    logic       clk;
    logic       rst_n;
    cpuReq_t    cpuReq [2];
    logic [1:0] reqReady;
    cpuRsp_t    cpuRsp [2];

    logic [WordWidth-1:0] refMem [MemWords];
    expRsp_t              expQ0 [$];
    expRsp_t              expQ1 [$];
    cpuReq_t              randReqs [2][RandReqs];
    int                   lastAccept [2];
    int                   lastRsp [2];
    int                   cycleCnt;
    int                   issued;
    int                   mismatchCnt;
    int                   otherErrCnt;
    logic [31:0]          seed;
    logic [NumLines-1:0]  validSnap;

    memSubsystem memSubsystem_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .cpuReq_i  (cpuReq),
        .reqReady_o(reqReady),
        .cpuRsp_o  (cpuRsp)
    );

    initial clk = 1'b0;
    always #(ClkPeriod / 2) clk = ~clk;

    always @(posedge clk) begin
        cycleCnt <= cycleCnt + 1;
    end

    task automatic checkValue(input logic [31:0] expVal, input logic [31:0] actVal,
                              input string msg);
        if (expVal !== actVal) begin
            $display("mismatch at %0t: %s expected %h got %h", $time, msg, expVal, actVal);
            mismatchCnt++;
        end
    endtask

    function automatic int wordIndex(input logic [AddrWidth-1:0] addr);
        return int'(addr[AddrWidth-1:2]) % MemWords;
    endfunction

    // reference model lookup
    function automatic logic [WordWidth-1:0] expectRead(input logic [AddrWidth-1:0] addr);
        return refMem[wordIndex(addr)];
    endfunction

    function automatic logic [WordWidth-1:0] applyMask(input logic [WordWidth-1:0] oldWord,
                                                       input logic [WordWidth-1:0] newWord,
                                                       input logic [3:0] mask);
        logic [WordWidth-1:0] res;
        res = oldWord;
        for (int b = 0; b < 4; b++) begin
            if (mask[b]) begin
                res[b*8 +: 8] = newWord[b*8 +: 8];
            end
        end
        return res;
    endfunction

    function automatic cpuReq_t makeReq(input cpuOp_e op, input logic [31:0] addr,
                                        input logic [31:0] data, input logic [3:0] mask);
        cpuReq_t r;
        r.valid  = 1'b1;
        r.op     = op;
        r.addr   = addr;
        r.wrData = data;
        r.wrMask = mask;
        return r;
    endfunction

    // roughly a quarter of the traffic goes to the uncached window
    function automatic cpuReq_t randomReq(input int lane);
        logic [31:0] rnd;
        logic [31:0] addr;
        logic [31:0] data;
        logic [3:0]  mask;
        rnd  = $random(seed);
        data = $random(seed);
        if (rnd[3:2] == 2'b00) begin
            addr = 32'h0000_0800 + lane * 32'h200 + {rnd[12:6], 2'b00};
        end else begin
            addr = 32'h8000_0000 + lane * 32'h400 + {rnd[13:6], 2'b00};
        end
        mask = (rnd[19:16] == 4'h0) ? 4'hF : rnd[19:16];
        return makeReq(rnd[0] ? opWrite : opRead, addr, data, mask);
    endfunction

    task automatic recordAccept(input int lane, input cpuReq_t req);
        expRsp_t e;
        e.isRead = (req.op == opRead);
        e.data   = e.isRead ? expectRead(req.addr) : '0;
        if (!e.isRead) begin
            refMem[wordIndex(req.addr)] = applyMask(expectRead(req.addr), req.wrData,
                                                    req.wrMask);
        end
        if (lane == 0) begin
            expQ0.push_back(e);
        end else begin
            expQ1.push_back(e);
        end
        lastAccept[lane] = cycleCnt;
        issued++;
    endtask

    // call right after a rising edge, returns at the accepting edge
    task automatic issueReq(input int lane, input cpuReq_t req);
        cpuReq[lane] <= req;
        do begin
            @(posedge clk);
        end while (!reqReady[lane]);
        recordAccept(lane, req);
    endtask

    task automatic releaseLane(input int lane);
        cpuReq[lane].valid <= 1'b0;
    endtask

    task automatic waitDrain(input int lane);
        while ((lane == 0 ? expQ0.size() : expQ1.size()) != 0) begin
            @(posedge clk);
        end
    endtask

    task automatic checkResponse(input int lane);
        expRsp_t e;
        if ((lane == 0 ? expQ0.size() : expQ1.size()) == 0) begin
            $display("error at %0t: lane %0d responded with no request pending", $time, lane);
            otherErrCnt++;
        end else begin
            lastRsp[lane] = cycleCnt;
            e = (lane == 0) ? expQ0.pop_front() : expQ1.pop_front();
            if (e.isRead) begin
                checkValue(e.data, cpuRsp[lane].rdData, $sformatf("lane %0d read", lane));
            end
        end
    endtask

    // compare process
    always @(posedge clk) begin
        if (rst_n) begin
            for (int lane = 0; lane < 2; lane++) begin
                if (cpuRsp[lane].valid) begin
                    checkResponse(lane);
                end
            end
        end
    end

    task automatic runLane(input int lane);
        for (int i = 0; i < RandReqs; i++) begin
            issueReq(lane, randReqs[lane][i]);
        end
        releaseLane(lane);
        waitDrain(lane);
    endtask

    initial begin
        #(WatchdogCycles * ClkPeriod);
        $display("timeout: simulation did not finish within %0d cycles", WatchdogCycles);
        $display("ERRORS FOUND");
        $finish;
    end

    initial begin
        cycleCnt    = 0;
        issued      = 0;
        mismatchCnt = 0;
        otherErrCnt = 0;
        seed        = 32'h1467;
        rst_n       = 1'b0;
        cpuReq[0]   = '0;
        cpuReq[1]   = '0;
        for (int w = 0; w < MemWords; w++) begin
            refMem[w] = '0;
        end
        for (int i = 0; i < RandReqs; i++) begin
            randReqs[0][i] = randomReq(0);
            randReqs[1][i] = randomReq(1);
        end

        // reset state during and just after reset
        repeat (2) @(posedge clk);
        checkValue(2'b11, reqReady, "reqReady in reset");
        checkValue(2'b00, {cpuRsp[1].valid, cpuRsp[0].valid}, "rsp valid in reset");
        rst_n <= 1'b1;
        @(posedge clk);
        checkValue(2'b11, reqReady, "reqReady after reset");
        checkValue(2'b00, {cpuRsp[1].valid, cpuRsp[0].valid}, "rsp valid after reset");

        // cold read then a hit in the same line
        issueReq(0, makeReq(opRead, 32'h8000_0000, '0, 4'h0));
        releaseLane(0);
        waitDrain(0);
        issueReq(0, makeReq(opRead, 32'h8000_0004, '0, 4'h0));
        releaseLane(0);
        waitDrain(0);
        checkValue(1, lastRsp[0] - lastAccept[0], "hit latency");

        // back-to-back byte-mask writes on lane 1
        issueReq(1, makeReq(opWrite, 32'h8000_0410, 32'h1122_3344, 4'hF));
        issueReq(1, makeReq(opWrite, 32'h8000_0410, 32'hAABB_CCDD, 4'b0101));
        issueReq(1, makeReq(opRead, 32'h8000_0410, '0, 4'h0));
        issueReq(1, makeReq(opWrite, 32'h8000_0414, 32'h5566_7788, 4'b1000));
        issueReq(1, makeReq(opRead, 32'h8000_0414, '0, 4'h0));
        releaseLane(1);
        waitDrain(1);

        // same index with another tag forces a dirty writeback
        issueReq(0, makeReq(opWrite, 32'h8000_0040, 32'hDEAD_BEEF, 4'hF));
        issueReq(0, makeReq(opRead, 32'h8000_0140, '0, 4'h0));
        issueReq(0, makeReq(opRead, 32'h8000_0040, '0, 4'h0));
        releaseLane(0);
        waitDrain(0);

        // uncached words must not allocate lines, index 8 is still empty here
        validSnap = memSubsystem_i.genLane[0].dataCache_i.validArr;
        issueReq(0, makeReq(opWrite, 32'h0000_0880, 32'hCAFE_F00D, 4'hF));
        issueReq(0, makeReq(opRead, 32'h0000_0880, '0, 4'h0));
        issueReq(0, makeReq(opWrite, 32'h0000_0884, 32'h1234_5678, 4'b0110));
        issueReq(0, makeReq(opRead, 32'h0000_0884, '0, 4'h0));
        releaseLane(0);
        waitDrain(0);
        checkValue(32'(validSnap), 32'(memSubsystem_i.genLane[0].dataCache_i.validArr),
                   "valid bits after uncached access");

        // both lanes at once sharing the memory credits
        fork
            runLane(0);
            runLane(1);
        join
        repeat (10) @(posedge clk);

        $display("summary: %0d mismatches, %0d other errors, %0d requests issued",
                 mismatchCnt, otherErrCnt, issued);
        if (mismatchCnt == 0 && otherErrCnt == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

/* build.f */
src/cachePkg.sv
src/busPkg.sv
src/dataCache.sv
src/busArbiter.sv
src/backingMemory.sv
src/memSubsystem.sv
dv/memSubsystemTb.sv

/* Bender.yml */
package:
  name: memSubsystem

sources:
  - files:
      - src/cachePkg.sv
      - src/busPkg.sv
      - src/dataCache.sv
      - src/busArbiter.sv
      - src/backingMemory.sv
      - src/memSubsystem.sv
  - target: test
    files:
      - dv/memSubsystemTb.sv
